// File: logic/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// ----------------------------------------------------------
// Build defaults for the dual-clock FIFO
// ----------------------------------------------------------

// Number of entries, a power of two for the gray pointers
`define FIFO_DEPTH 16

// Width of one stored word
`define FIFO_DATA_WID 32

// Flops in each clock-crossing synchronizer chain
`define FIFO_SYNC_STAGES 2

`endif

// File: logic/fifo_pkg.sv
`include "fifo_consts.svh"

package fifo_pkg;

    // Flag style per side
    // Timing registers the flags, latency derives them from the pointers
    typedef enum logic {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    // Address width of the default depth
    localparam int PTR_WID = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;

    // Memory address
    typedef logic [PTR_WID-1:0] ptr_t;

    // Extended pointer with wrap bit, also used as fill count
    typedef logic [PTR_WID:0] cnt_t;

endpackage : fifo_pkg

// File: logic/fifo_data_pkg.sv
`include "fifo_consts.svh"

package fifo_data_pkg;

    // One stored word
    typedef logic [`FIFO_DATA_WID-1:0] data_t;

endpackage : fifo_data_pkg

// File: logic/fifo_mem_if.sv
interface fifo_mem_if;

    // Write port, wr_clk domain
    logic                 wr_en;
    fifo_pkg::ptr_t       wr_ptr;
    fifo_data_pkg::data_t wr_data;

    // Read port, rd_clk domain
    logic                 rd_en;
    fifo_pkg::ptr_t       rd_ptr;
    fifo_data_pkg::data_t rd_data;

    // Pointer and flag controller
    modport ctrl (
        output wr_en,
        output wr_ptr,
        output rd_en,
        output rd_ptr
    );

    // Storage array
    modport mem (
        input  wr_en,
        input  wr_ptr,
        input  wr_data,
        input  rd_en,
        input  rd_ptr,
        output rd_data
    );

    // Data path at the top level
    modport port (
        output wr_data,
        input  rd_data
    );

endinterface : fifo_mem_if

// File: logic/sync_ctr.sv
`include "fifo_consts.svh"

module sync_ctr #(
    parameter bit DECODE_OUT = 1'b1,
    parameter int STAGES     = `FIFO_SYNC_STAGES
) (
    // Source side
    input  logic           clk_in,
    input  logic           rst_in,
    input  fifo_pkg::cnt_t cnt_in,

    // Destination side
    input  logic           clk_out,
    input  logic           rst_out,
    output fifo_pkg::cnt_t cnt_out
);

    // Gray code changes one bit per increment, so a sample
    // taken mid-change resolves to the old or the new count
    function automatic fifo_pkg::cnt_t bin_to_gray(input fifo_pkg::cnt_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic fifo_pkg::cnt_t gray_to_bin(input fifo_pkg::cnt_t gray);
        fifo_pkg::cnt_t bin;
        bin[$bits(bin)-1] = gray[$bits(gray)-1];
        for (int i = $bits(gray) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // ----------------------------------------------------------
    // Source domain
    // ----------------------------------------------------------
    fifo_pkg::cnt_t gray_q;

    // Registered so no combinational glitch reaches the crossing
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            gray_q <= '0;
        end else begin
            gray_q <= bin_to_gray(cnt_in);
        end
    end

    // ----------------------------------------------------------
    // Destination domain
    // ----------------------------------------------------------
    fifo_pkg::cnt_t sync_q [STAGES];

    always_ff @(posedge clk_out) begin
        if (rst_out) begin
            for (int s = 0; s < STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= gray_q;
            for (int s = 1; s < STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // Binary back out, or raw gray when the user compares gray
    assign cnt_out = DECODE_OUT ? gray_to_bin(sync_q[STAGES-1]) : sync_q[STAGES-1];

endmodule : sync_ctr

// File: logic/fifo_ctrl_fsm.sv
`include "fifo_consts.svh"

module fifo_ctrl_fsm #(
    parameter int                  DEPTH       = `FIFO_DEPTH,
    parameter bit                  ASYNC       = 1'b1,
    parameter bit                  OFLOW_PROT  = 1'b1,
    parameter bit                  UFLOW_PROT  = 1'b1,
    parameter fifo_pkg::opt_mode_t WR_OPT_MODE = fifo_pkg::OPT_MODE_TIMING,
    parameter fifo_pkg::opt_mode_t RD_OPT_MODE = fifo_pkg::OPT_MODE_TIMING
) (
    // Write domain
    input  logic           wr_clk,
    input  logic           wr_srst,
    input  logic           wr,
    input  logic           mem_rdy,
    output logic           wr_rdy,
    output logic           wr_full,
    output logic           wr_oflow,
    output fifo_pkg::cnt_t wr_count,

    // Read domain
    input  logic           rd_clk,
    input  logic           rd_srst,
    input  logic           rd,
    output logic           rd_empty,
    output logic           rd_uflow,
    output fifo_pkg::cnt_t rd_count,

    // Memory side
    fifo_mem_if.ctrl       mem
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic           wr_safe;
    logic           rd_safe;
    fifo_pkg::cnt_t wr_ptr_q;
    fifo_pkg::cnt_t rd_ptr_q;
    fifo_pkg::cnt_t wr_cnt_raw;
    fifo_pkg::cnt_t rd_cnt_raw;

    // ----------------------------------------------------------
    // Write side
    // ----------------------------------------------------------
    assign wr_safe  = OFLOW_PROT ? (wr && wr_rdy) : wr;
    assign wr_oflow = wr && !wr_rdy;

    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            wr_ptr_q <= '0;
        end else if (wr_safe) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    assign mem.wr_en  = wr_safe;
    assign mem.wr_ptr = wr_ptr_q[PTR_WID-1:0];

    // ----------------------------------------------------------
    // Read side
    // ----------------------------------------------------------
    assign rd_safe  = UFLOW_PROT ? (rd && !rd_empty) : rd;
    assign rd_uflow = rd && rd_empty;

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_ptr_q <= '0;
        end else if (rd_safe) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    assign mem.rd_en  = rd_safe;
    assign mem.rd_ptr = rd_ptr_q[PTR_WID-1:0];

    // ----------------------------------------------------------
    // Fill counts
    // ----------------------------------------------------------
    if (ASYNC) begin : g_async
        fifo_pkg::cnt_t wr_ptr_rdclk;
        fifo_pkg::cnt_t rd_ptr_wrclk;

        sync_ctr #(.DECODE_OUT(1'b1)) u_sync_wr_ptr (
            .clk_in  (wr_clk),
            .rst_in  (wr_srst),
            .cnt_in  (wr_ptr_q),
            .clk_out (rd_clk),
            .rst_out (rd_srst),
            .cnt_out (wr_ptr_rdclk)
        );

        sync_ctr #(.DECODE_OUT(1'b1)) u_sync_rd_ptr (
            .clk_in  (rd_clk),
            .rst_in  (rd_srst),
            .cnt_in  (rd_ptr_q),
            .clk_out (wr_clk),
            .rst_out (wr_srst),
            .cnt_out (rd_ptr_wrclk)
        );

        // Each side sees a stale opposite pointer, so counts are conservative
        assign wr_cnt_raw = wr_ptr_q - rd_ptr_wrclk;
        assign rd_cnt_raw = wr_ptr_rdclk - rd_ptr_q;
    end else begin : g_sync
        assign wr_cnt_raw = wr_ptr_q - rd_ptr_q;
        assign rd_cnt_raw = wr_ptr_q - rd_ptr_q;
    end

    // ----------------------------------------------------------
    // Write flags
    // ----------------------------------------------------------
    if (WR_OPT_MODE == fifo_pkg::OPT_MODE_TIMING) begin : g_wr_timing
        // Own writes fold in at once, remote reads arrive a cycle late
        always_ff @(posedge wr_clk) begin
            if (wr_srst) begin
                wr_count <= '0;
                wr_full  <= 1'b0;
            end else if (wr_safe) begin
                wr_count <= wr_cnt_raw + 1'b1;
                wr_full  <= (wr_cnt_raw >= DEPTH - 1);
            end else begin
                wr_count <= wr_cnt_raw;
                wr_full  <= (wr_cnt_raw == DEPTH);
            end
        end

        always_ff @(posedge wr_clk) begin
            if (wr_srst || !mem_rdy) begin
                wr_rdy <= 1'b0;
            end else if (wr_safe) begin
                wr_rdy <= (wr_cnt_raw < DEPTH - 1);
            end else begin
                wr_rdy <= (wr_cnt_raw < DEPTH);
            end
        end
    end else begin : g_wr_latency
        assign wr_count = wr_cnt_raw;
        assign wr_full  = (wr_cnt_raw == DEPTH);
        assign wr_rdy   = mem_rdy && (wr_cnt_raw < DEPTH);
    end

    // ----------------------------------------------------------
    // Read flags
    // ----------------------------------------------------------
    if (RD_OPT_MODE == fifo_pkg::OPT_MODE_TIMING) begin : g_rd_timing
        always_ff @(posedge rd_clk) begin
            if (rd_srst) begin
                rd_count <= '0;
                rd_empty <= 1'b1;
            end else if (rd_safe) begin
                rd_count <= rd_cnt_raw - 1'b1;
                rd_empty <= (rd_cnt_raw <= 1);
            end else begin
                rd_count <= rd_cnt_raw;
                rd_empty <= (rd_cnt_raw == 0);
            end
        end
    end else begin : g_rd_latency
        assign rd_count = rd_cnt_raw;
        assign rd_empty = (rd_cnt_raw == 0);
    end

endmodule : fifo_ctrl_fsm

// File: logic/fifo_mem.sv
`include "fifo_consts.svh"

module fifo_mem #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic    wr_clk,
    input  logic    wr_srst,
    input  logic    rd_clk,
    output logic    mem_rdy,
    fifo_mem_if.mem mem
);

    fifo_data_pkg::data_t ram [DEPTH];

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_ptr] <= mem.wr_data;
        end
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------
    // One rd_clk from enable to data
    always_ff @(posedge rd_clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_ptr];
        end
    end

    // Stand-in for initialization, done a cycle after reset
    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            mem_rdy <= 1'b0;
        end else begin
            mem_rdy <= 1'b1;
        end
    end

endmodule : fifo_mem

// File: logic/fifo_async.sv
`include "fifo_consts.svh"

module fifo_async #(
    parameter bit                  ASYNC       = 1'b1,
    parameter bit                  OFLOW_PROT  = 1'b1,
    parameter bit                  UFLOW_PROT  = 1'b1,
    parameter fifo_pkg::opt_mode_t WR_OPT_MODE = fifo_pkg::OPT_MODE_TIMING,
    parameter fifo_pkg::opt_mode_t RD_OPT_MODE = fifo_pkg::OPT_MODE_TIMING
) (
    // Write domain
    input  logic                 wr_clk,
    input  logic                 wr_srst,
    input  logic                 wr,
    input  fifo_data_pkg::data_t wr_data,
    output logic                 wr_rdy,
    output logic                 wr_full,
    output logic                 wr_oflow,
    output fifo_pkg::cnt_t       wr_count,

    // Read domain
    input  logic                 rd_clk,
    input  logic                 rd_srst,
    input  logic                 rd,
    output fifo_data_pkg::data_t rd_data,
    output logic                 rd_empty,
    output logic                 rd_uflow,
    output fifo_pkg::cnt_t       rd_count
);

    logic mem_rdy;

    fifo_mem_if mem_if ();

    // Data words bypass the controller
    assign mem_if.wr_data = wr_data;
    assign rd_data        = mem_if.rd_data;

    // ----------------------------------------------------------
    // Pointers and flags
    // ----------------------------------------------------------
    fifo_ctrl_fsm #(
        .DEPTH       (`FIFO_DEPTH),
        .ASYNC       (ASYNC),
        .OFLOW_PROT  (OFLOW_PROT),
        .UFLOW_PROT  (UFLOW_PROT),
        .WR_OPT_MODE (WR_OPT_MODE),
        .RD_OPT_MODE (RD_OPT_MODE)
    ) u_ctrl (
        .wr_clk   (wr_clk),
        .wr_srst  (wr_srst),
        .wr       (wr),
        .mem_rdy  (mem_rdy),
        .wr_rdy   (wr_rdy),
        .wr_full  (wr_full),
        .wr_oflow (wr_oflow),
        .wr_count (wr_count),
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .rd       (rd),
        .rd_empty (rd_empty),
        .rd_uflow (rd_uflow),
        .rd_count (rd_count),
        .mem      (mem_if.ctrl)
    );

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    fifo_mem #(
        .DEPTH (`FIFO_DEPTH)
    ) u_mem (
        .wr_clk  (wr_clk),
        .wr_srst (wr_srst),
        .rd_clk  (rd_clk),
        .mem_rdy (mem_rdy),
        .mem     (mem_if.mem)
    );

endmodule : fifo_async

// File: bench/fifo_sva.sv
`include "fifo_consts.svh"

module fifo_sva (
    input logic           wr_clk,
    input logic           wr_srst,
    input logic           rd_clk,
    input logic           rd_srst,
    input logic           wr,
    input logic           wr_rdy,
    input logic           wr_full,
    input logic           wr_oflow,
    input fifo_pkg::cnt_t wr_count,
    input logic           rd_empty,
    input logic           rd_uflow
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------
    // Protection strobes
    // ----------------------------------------------------------
    a_oflow_blocked: assert property (@(posedge wr_clk) disable iff (wr_srst)
        wr_oflow |-> (wr && !wr_rdy))
        else $error("wr_oflow raised without a blocked write");

    a_uflow_empty: assert property (@(posedge rd_clk) disable iff (rd_srst)
        rd_uflow |-> rd_empty)
        else $error("rd_uflow raised while not empty");

    // ----------------------------------------------------------
    // Flags and count
    // ----------------------------------------------------------
    a_full_empty: assert property (@(posedge wr_clk) disable iff (wr_srst || rd_srst)
        !(wr_full && rd_empty))
        else $error("wr_full and rd_empty set together");

    a_count_range: assert property (@(posedge wr_clk) disable iff (wr_srst)
        wr_count <= `FIFO_DEPTH)
        else $error("wr_count above depth");

endmodule : fifo_sva

bind fifo_async fifo_sva i_sva (.*);

// File: bench/fifo_tb.sv
`include "fifo_consts.svh"

module fifo_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROBE_OFLOW = 1;
    localparam int PROBE_UFLOW = 2;
    localparam int RD_PERIOD   = 6;
    localparam int NUM_ROWS    = 6;

    typedef struct packed {
        logic [7:0]     n_wr;
        logic [7:0]     n_rd;
        logic [3:0]     gap;
        logic [1:0]     probe;
        logic           full;
        logic           empty;
        fifo_pkg::cnt_t cnt;
    } row_t;

    // Writes, reads, read gap, probe, then settled full, empty and count
    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'd5,  8'd3,  4'd0, 2'd0, 1'b0, 1'b0, 5'd2},
        '{8'd20, 8'd20, 4'd1, 2'd0, 1'b0, 1'b0, 5'd2},
        '{8'd14, 8'd0,  4'd0, 2'd1, 1'b1, 1'b0, 5'd16},
        '{8'd0,  8'd16, 4'd2, 2'd2, 1'b0, 1'b1, 5'd0},
        '{8'd3,  8'd3,  4'd3, 2'd0, 1'b0, 1'b1, 5'd0},
        '{8'd9,  8'd4,  4'd0, 2'd0, 1'b0, 1'b0, 5'd5}
    };

    logic                 wr_clk, wr_srst, wr, wr_rdy, wr_full, wr_oflow;
    logic                 rd_clk, rd_srst, rd, rd_empty, rd_uflow;
    fifo_data_pkg::data_t wr_data, rd_data;
    fifo_pkg::cnt_t       wr_count, rd_count;
    fifo_data_pkg::data_t model [$];

    fifo_async i_dut (.*);

    always #2 wr_clk = ~wr_clk;
    always #3 rd_clk = ~rd_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic check_data(input string name, input fifo_data_pkg::data_t act,
                              input fifo_data_pkg::data_t exp);
        if (act !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, act, exp));
    endtask

    task automatic check_count(input string name, input fifo_pkg::cnt_t act,
                               input fifo_pkg::cnt_t exp);
        if (act !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, act, exp));
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, act, exp));
    endtask

    // ----------------------------------------------------------
    // Handshakes start a nanosecond after their own clock edge
    // ----------------------------------------------------------
    task automatic push_word(input fifo_data_pkg::data_t d);
        logic taken;
        wr      = 1'b1;
        wr_data = d;
        do begin
            // Mid-cycle value of wr_rdy is the one the next edge sees
            #2 taken = wr_rdy;
            @(posedge wr_clk);
            #1;
        end while (!taken);
        model.push_back(d);
        wr = 1'b0;
    endtask

    task automatic pop_word();
        logic taken;
        rd = 1'b1;
        do begin
            #4 taken = !rd_empty;
            @(posedge rd_clk);
            #1;
        end while (!taken);
        rd = 1'b0;
        if (model.size() == 0) abort_run("A read was accepted with nothing written");
        check_data("rd_data", rd_data, model.pop_front());
    endtask

    task automatic settle();
        repeat (8) @(posedge rd_clk);
        @(posedge wr_clk);
        #2;
    endtask

    task automatic probe_overflow();
        @(posedge wr_clk);
        #1 wr = 1'b1;
        wr_data = 32'hbad0_f00d;
        #2;
        check_flag("wr_oflow", wr_oflow, 1'b1);
        check_flag("wr_rdy", wr_rdy, 1'b0);
        @(posedge wr_clk);
        #1 wr = 1'b0;
    endtask

    task automatic probe_underflow();
        @(posedge rd_clk);
        #1 rd = 1'b1;
        #3;
        check_flag("rd_uflow", rd_uflow, 1'b1);
        @(posedge rd_clk);
        #1 rd = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        fork
            begin
                @(posedge wr_clk);
                #1;
                for (int i = 0; i < row.n_wr; i++) push_word($urandom());
            end
            begin
                @(posedge rd_clk);
                #1;
                for (int i = 0; i < row.n_rd; i++) begin
                    pop_word();
                    repeat (row.gap) begin
                        @(posedge rd_clk);
                        #1;
                    end
                end
            end
        join
        settle();
        if (row.probe == PROBE_OFLOW) probe_overflow();
        else if (row.probe == PROBE_UFLOW) probe_underflow();
        settle();
        check_flag("wr_full", wr_full, row.full);
        check_flag("wr_rdy", wr_rdy, !row.full);
        check_flag("rd_empty", rd_empty, row.empty);
        check_count("wr_count", wr_count, row.cnt);
        check_count("rd_count", rd_count, row.cnt);
        check_count("model size", fifo_pkg::cnt_t'(model.size()), row.cnt);
    endtask

    // Eight read periods per table operation, plus reset and settling
    function automatic int watchdog_ns();
        int total;
        total = 0;
        foreach (ROWS[r]) total += ROWS[r].n_wr + ROWS[r].n_rd + 1;
        return total * 8 * RD_PERIOD + 2000;
    endfunction

    initial begin
        int limit_ns;
        limit_ns = watchdog_ns();
        #(limit_ns);
        abort_run("Run timed out before the stimulus table finished");
    end

    initial begin
        int cycles;
        void'($urandom(41817));
        {wr_clk, rd_clk, wr, rd} = '0;
        {wr_srst, rd_srst}       = 2'b11;
        wr_data                  = '0;
        repeat (8) @(posedge wr_clk);
        #1 {wr_srst, rd_srst} = 2'b00;
        check_flag("wr_rdy", wr_rdy, 1'b0);
        check_flag("rd_empty", rd_empty, 1'b1);
        check_flag("wr_oflow", wr_oflow, 1'b0);
        check_flag("rd_uflow", rd_uflow, 1'b0);
        check_count("wr_count", wr_count, '0);
        check_count("rd_count", rd_count, '0);
        // Memory ready first, then wr_rdy a cycle later
        cycles = 0;
        while (!wr_rdy) begin
            if (cycles == 4) abort_run("wr_rdy did not rise after reset");
            @(posedge wr_clk);
            #1 cycles++;
        end
        for (int r = 0; r < NUM_ROWS; r++) run_row(ROWS[r]);
        $display("Test passed");
        $finish;
    end

endmodule : fifo_tb

// File: sim.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_data_pkg.sv
logic/fifo_mem_if.sv
logic/sync_ctr.sv
logic/fifo_ctrl_fsm.sv
logic/fifo_mem.sv
logic/fifo_async.sv
bench/fifo_sva.sv
bench/fifo_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = fifo_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
